// ==== list.f ====
common/timer_pkg.sv
rtl/prescaler.sv
timer/timer_core.sv
timer/seed_mixer.sv
rtl/sequence_trigger.sv
rtl/timer_host.sv
testbench/timer_host_properties.sv
testbench/timer_host_tb.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the timer host

VERILATOR ?= verilator
TOP       ?= timer_host_tb
RTL_TOP   ?= timer_host
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/timer_host_tb.sv ====
// Table-driven testbench for the timer host with a cycle model
// of the mixer stream and the sequence trigger
`timescale 1ns/1ns

module timer_host_tb;

    localparam logic [2:0] kind_match       = 3'd0;
    localparam logic [2:0] kind_overflow    = 3'd1;
    localparam logic [2:0] kind_stop_enable = 3'd2;
    localparam logic [2:0] kind_stop_reset  = 3'd3;
    localparam logic [2:0] kind_clear       = 3'd4;
    localparam int         num_rows         = 11;

    typedef struct packed {
        timer_pkg::count_t load;
        timer_pkg::count_t compare;
        logic [3:0]        ticks;  // Ticks from load to the compare value
        logic [2:0]        kind;
        logic              rnd;    // Load and compare drawn at run time
    } row_t;

    row_t rows [num_rows] = '{
        '{16'h0010, 16'h0012, 4'd2, kind_match,       1'b0},
        '{16'h0100, 16'h0100, 4'd0, kind_match,       1'b0},
        '{16'hFFFE, 16'h1234, 4'd2, kind_overflow,    1'b0},
        '{16'h0020, 16'h0030, 4'd1, kind_stop_enable, 1'b0},
        '{16'h0040, 16'h0050, 4'd1, kind_stop_reset,  1'b0},
        '{16'h0000, 16'h0000, 4'd0, kind_clear,       1'b1},
        '{16'h0000, 16'h0000, 4'd0, kind_match,       1'b1},
        '{16'h0000, 16'h0000, 4'd0, kind_match,       1'b1},
        '{16'h0000, 16'h0000, 4'd0, kind_match,       1'b1},
        '{16'h0000, 16'h0000, 4'd0, kind_match,       1'b1},
        '{16'h0000, 16'h0000, 4'd0, kind_match,       1'b1}
    };

    logic              clk;
    logic              rst;
    timer_pkg::count_t timer_load;
    logic              timer_enable;
    logic              timer_reset;
    timer_pkg::count_t compare_value;
    timer_pkg::count_t timer_count;
    logic              timer_overflow;
    logic              timer_match;
    logic              timer_active;

    // Values applied on the next rising edge
    logic              drv_rst;
    logic              drv_enable;
    logic              drv_reset;
    timer_pkg::count_t drv_load;
    timer_pkg::count_t drv_compare;

    // Mixer and trigger model, plus what the DUT sees at the coming edge
    timer_pkg::lfsr_t    m_lfsr;
    timer_pkg::mix_sel_t m_sel;
    logic [7:0]          m_prev;
    logic                m_fc;
    logic                s_rst = 1'b1;
    logic                s_enable;
    logic                s_active;
    timer_pkg::count_t   s_count;
    timer_pkg::count_t   s_compare;

    int          match_seen;
    int          ovf_seen;
    logic        row_cleared;
    logic        clear_due = 1'b0;
    logic [31:0] rng;

    timer_host dut_i (
        .clk            (clk),
        .rst            (rst),
        .timer_load     (timer_load),
        .timer_enable   (timer_enable),
        .timer_reset    (timer_reset),
        .compare_value  (compare_value),
        .timer_count    (timer_count),
        .timer_overflow (timer_overflow),
        .timer_match    (timer_match),
        .timer_active   (timer_active)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        if (s[0]) begin
            galois_step = (s >> 1) ^ 32'h80200003;
        end else begin
            galois_step = s >> 1;
        end
    endfunction

    task automatic rand_bits(input int n, output timer_pkg::count_t value);
        value = '0;
        for (int b = 0; b < n; b++) begin
            rng   = galois_step(rng);
            value = {value[14:0], rng[0]};
        end
    endtask

    // Mixer LFSR shifted left once, taps 31, 27, 15 and 2
    function automatic timer_pkg::lfsr_t lfsr_next(input timer_pkg::lfsr_t s);
        lfsr_next = {s[30:0], s[31] ^ s[27] ^ s[15] ^ s[2]};
    endfunction

    // Stream byte from the selector rule
    function automatic logic [7:0] mix_select(input timer_pkg::lfsr_t lfsr,
                                              input timer_pkg::mix_sel_t sel,
                                              input timer_pkg::count_t count,
                                              input timer_pkg::count_t compare);
        logic [4:0]  base;
        logic [31:0] folded;
        logic [7:0]  seed_byte;
        base      = {sel[1:0], 3'b000};
        folded    = {compare, count};
        seed_byte = lfsr[base +: 8];
        if (sel[2]) begin
            mix_select = seed_byte ^ folded[base +: 8];
        end else begin
            mix_select = seed_byte;
        end
    endfunction

    // Advances the model across the edge that just passed
    task automatic model_step();
        logic [7:0] mix;
        if (s_rst) begin
            m_lfsr = timer_pkg::timer_seed;
            m_sel  = '0;
            m_prev = 8'h00;
            m_fc   = 1'b0;
        end else begin
            mix    = mix_select(m_lfsr, m_sel, s_count, s_compare);
            m_fc   = (m_prev == timer_pkg::trigger_first) && (mix == timer_pkg::trigger_second);
            m_prev = mix;
            if (s_enable || s_active) begin
                m_lfsr = lfsr_next(m_lfsr);
                m_sel  = m_sel + 1'b1;
            end
        end
        s_rst     = rst;
        s_enable  = timer_enable;
        s_compare = compare_value;
        s_count   = timer_count;
        s_active  = timer_active;
    endtask

    task automatic check_count(input string name, input timer_pkg::count_t got,
                               input timer_pkg::count_t expected);
        if (got !== expected) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, expected);
            $display("Test failed");
            $fatal(1, "%s check", name);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, expected);
            $display("Test failed");
            $fatal(1, "%s check", name);
        end
    endtask

    task automatic report_timeout(input string what, input int idx);
        $display("Timed out waiting for %s in row %0d", what, idx);
        $display("Test failed");
        $fatal(1, "timeout");
    endtask

    // One clock. Inputs change on the rising edge, outputs are read on the falling edge
    task automatic clock_cycle();
        @(posedge clk);
        rst           <= drv_rst;
        timer_load    <= drv_load;
        timer_enable  <= drv_enable;
        timer_reset   <= drv_reset;
        compare_value <= drv_compare;
        @(negedge clk);
        model_step();
        if (timer_match) match_seen++;
        if (timer_overflow) ovf_seen++;
        if (clear_due) begin  // Trigger fired on the previous edge
            check_count("timer_count", timer_count, '0);
            check_flag("timer_active", timer_active, 1'b0);
            check_flag("timer_match", timer_match, 1'b0);
            check_flag("timer_overflow", timer_overflow, 1'b0);
            row_cleared = 1'b1;
        end
        clear_due = m_fc;
    endtask

    task automatic run_row(input int idx);
        row_t              row;
        timer_pkg::count_t load;
        timer_pkg::count_t compare;
        timer_pkg::count_t k;
        timer_pkg::lfsr_t  next_lfsr;
        int                limit;
        int                waited;
        row     = rows[idx];
        load    = row.load;
        compare = row.compare;
        k       = timer_pkg::count_t'(row.ticks);
        if (row.rnd) begin
            rand_bits(15, load);  // Keeps the match below the wrap
            rand_bits(2, k);
            k       = k + 1'b1;
            compare = load + k;
        end
        match_seen  = 0;
        ovf_seen    = 0;
        row_cleared = 1'b0;

        // Counter cleared while idle
        drv_load    = load;
        drv_compare = compare;
        drv_enable  = 1'b0;
        drv_reset   = 1'b1;
        clock_cycle();
        drv_reset = 1'b0;
        repeat (2) clock_cycle();
        if (!row_cleared) check_count("timer_count", timer_count, '0);

        drv_enable = 1'b1;
        repeat (2) clock_cycle();
        if (!row_cleared) check_flag("timer_active", timer_active, 1'b1);
        clock_cycle();
        if (!row_cleared) check_count("timer_count", timer_count, load);

        waited = 0;
        if (row.kind == kind_match || row.kind == kind_overflow) begin
            limit = (int'(k) + 2) * timer_pkg::prescale_ratio + 8;
            while (match_seen == 0 && ovf_seen == 0 && !row_cleared) begin
                if (waited >= limit) report_timeout("a timer flag", idx);
                else begin
                    clock_cycle();
                    waited++;
                end
            end
            if (!row_cleared) begin
                check_flag("timer_match", match_seen != 0, row.kind == kind_match);
                check_flag("timer_overflow", ovf_seen != 0, row.kind == kind_overflow);
            end
            if (!row_cleared && row.kind == kind_match) begin
                repeat (2) clock_cycle();
                if (!row_cleared) begin
                    check_count("timer_count", timer_count, compare + 1'b1);
                    check_flag("timer_match pulse count", match_seen == 1, 1'b1);
                end
            end else if (!row_cleared) begin
                clock_cycle();
                if (!row_cleared) check_count("timer_count", timer_count, '0);
                waited = 0;
                while (timer_count != 16'h0001 && !row_cleared) begin
                    if (waited >= timer_pkg::prescale_ratio + 8) begin
                        report_timeout("the count after overflow", idx);
                    end else begin
                        clock_cycle();
                        waited++;
                    end
                end
                if (!row_cleared) check_flag("timer_overflow pulse count", ovf_seen == 1, 1'b1);
            end
        end else if (row.kind == kind_clear) begin
            // From selector slot 5, pick compare bytes that turn slots 6 and 7 into the pattern
            while (m_sel != 3'd5 && !row_cleared) begin
                if (waited >= 16) report_timeout("selector slot 5", idx);
                else begin
                    clock_cycle();
                    waited++;
                end
            end
            next_lfsr         = lfsr_next(m_lfsr);
            drv_compare[7:0]  = next_lfsr[23:16] ^ timer_pkg::trigger_first;
            next_lfsr         = lfsr_next(next_lfsr);
            drv_compare[15:8] = next_lfsr[31:24] ^ timer_pkg::trigger_second;
            waited = 0;
            while (!row_cleared) begin
                if (waited >= 8) report_timeout("the forced clear", idx);
                else begin
                    clock_cycle();
                    waited++;
                end
            end
        end else begin
            // Run one tick past the load, then stop
            while (timer_count != load + 1'b1 && !row_cleared) begin
                if (waited >= 2 * timer_pkg::prescale_ratio + 8) report_timeout("a tick", idx);
                else begin
                    clock_cycle();
                    waited++;
                end
            end
            if (row.kind == kind_stop_enable) drv_enable = 1'b0;
            else drv_reset = 1'b1;
            repeat (2) clock_cycle();
            if (!row_cleared) check_flag("timer_active", timer_active, 1'b0);
            drv_reset = 1'b0;
        end

        drv_enable = 1'b0;
        repeat (2) clock_cycle();
        check_flag("timer_active", timer_active, 1'b0);
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        timer_load    = '0;
        timer_enable  = 1'b0;
        timer_reset   = 1'b0;
        compare_value = '0;
        drv_rst       = 1'b1;
        drv_enable    = 1'b0;
        drv_reset     = 1'b0;
        drv_load      = '0;
        drv_compare   = '0;
        rng           = 32'hbbc30a03;
        repeat (2) clock_cycle();
        drv_rst = 1'b0;
        clock_cycle();

        check_count("timer_count", timer_count, '0);
        check_flag("timer_active", timer_active, 1'b0);
        check_flag("timer_match", timer_match, 1'b0);
        check_flag("timer_overflow", timer_overflow, 1'b0);

        for (int i = 0; i < num_rows; i++) begin
            run_row(i);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== testbench/timer_host_properties.sv ====
// Concurrent checks on the timer flags and the forced clear,
// bound into the timer host
`timescale 1ns/1ns

module timer_host_properties (
    input logic clk,
    input logic rst,
    input logic timer_match,
    input logic timer_overflow,
    input logic timer_active,
    input logic force_clear
);

    logic any_flag;

    assign any_flag = timer_match || timer_overflow;

    // Flags are single-cycle pulses
    flag_pulse_a: assert property (@(posedge clk) disable iff (rst)
        any_flag |=> !any_flag)
        else $error("timer flag high on two consecutive cycles");

    flags_exclusive_a: assert property (@(posedge clk) disable iff (rst)
        !(timer_match && timer_overflow))
        else $error("timer_match and timer_overflow high together");

    // Hidden clear drops the timer to idle
    clear_stops_a: assert property (@(posedge clk) disable iff (rst)
        force_clear |=> !timer_active)
        else $error("timer_active still high after a forced clear");

endmodule

bind timer_host timer_host_properties props_i (
    .clk            (clk),
    .rst            (rst),
    .timer_match    (timer_match),
    .timer_overflow (timer_overflow),
    .timer_active   (timer_active),
    .force_clear    (force_clear)
);

// ==== rtl/timer_host.sv ====
// Timer host top level with prescaler, timer core,
// seed mixer and sequence trigger
`timescale 1ns/1ns

module timer_host (
    input  logic              clk,
    input  logic              rst,
    input  timer_pkg::count_t timer_load,
    input  logic              timer_enable,
    input  logic              timer_reset,
    input  timer_pkg::count_t compare_value,
    output timer_pkg::count_t timer_count,
    output logic              timer_overflow,
    output logic              timer_match,
    output logic              timer_active
);

    logic       tick;         // Count tick from the prescaler
    logic       force_clear;  // Hidden clear pulse
    logic [7:0] mix_byte;     // Pseudo-random stream byte

    prescaler prescaler_i (
        .clk         (clk),
        .rst         (rst),
        .active      (timer_active),
        .force_clear (force_clear),
        .tick        (tick)
    );

    timer_core timer_core_i (
        .clk            (clk),
        .rst            (rst),
        .tick           (tick),
        .force_clear    (force_clear),
        .timer_load     (timer_load),
        .timer_enable   (timer_enable),
        .timer_reset    (timer_reset),
        .compare_value  (compare_value),
        .timer_count    (timer_count),
        .timer_overflow (timer_overflow),
        .timer_match    (timer_match),
        .timer_active   (timer_active)
    );

    // Stream source for the trigger
    seed_mixer seed_mixer_i (
        .clk           (clk),
        .rst           (rst),
        .timer_enable  (timer_enable),
        .timer_active  (timer_active),
        .timer_count   (timer_count),
        .compare_value (compare_value),
        .mix_byte      (mix_byte)
    );

    sequence_trigger sequence_trigger_i (
        .clk         (clk),
        .rst         (rst),
        .mix_byte    (mix_byte),
        .force_clear (force_clear)
    );

endmodule

// ==== rtl/sequence_trigger.sv ====
// Two-byte sequence detector driving the forced timer clear
`timescale 1ns/1ns

module sequence_trigger (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] mix_byte,
    output logic       force_clear
);

    logic [7:0] prev_byte;
    logic       seen_first;
    logic       seen_second;
    logic       hit;

    // Pattern is trigger_first then trigger_second on adjacent cycles
    assign seen_first  = (prev_byte == timer_pkg::trigger_first);
    assign seen_second = (mix_byte == timer_pkg::trigger_second);
    assign hit         = seen_first && seen_second;

    // Previous stream byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_byte <= 8'h00;
        end else begin
            prev_byte <= mix_byte;
        end
    end

    // Registered pulse, lands one cycle after the second byte.
    // prev_byte then holds trigger_second, so the pulse cannot repeat
    // on the next cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            force_clear <= 1'b0;
        end else begin
            force_clear <= hit;
        end
    end

endmodule

// ==== timer/seed_mixer.sv ====
// 32-bit LFSR and rotating byte selector that mixes seed,
// count and compare bytes into the trigger stream
`timescale 1ns/1ns

module seed_mixer (
    input  logic              clk,
    input  logic              rst,
    input  logic              timer_enable,
    input  logic              timer_active,
    input  timer_pkg::count_t timer_count,
    input  timer_pkg::count_t compare_value,
    output logic [7:0]        mix_byte
);

    timer_pkg::lfsr_t    lfsr;
    timer_pkg::mix_sel_t sel;
    logic                feedback;
    logic                step;

    // Taps 31, 27, 15 and 2
    assign feedback = lfsr[31] ^ lfsr[27] ^ lfsr[15] ^ lfsr[2];
    assign step     = timer_enable || timer_active;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= timer_pkg::timer_seed;
            sel  <= '0;
        end else if (step) begin
            lfsr <= {lfsr[30:0], feedback};  // Shift left
            sel  <= sel + 1'b1;
        end
    end

    // Upper four slots fold in count and compare bytes
    always_comb begin
        case (sel)
            3'd0: mix_byte = lfsr[7:0];
            3'd1: mix_byte = lfsr[15:8];
            3'd2: mix_byte = lfsr[23:16];
            3'd3: mix_byte = lfsr[31:24];
            3'd4: mix_byte = lfsr[7:0] ^ timer_count[7:0];
            3'd5: mix_byte = lfsr[15:8] ^ timer_count[timer_pkg::timer_width-1 -: 8];
            3'd6: mix_byte = lfsr[23:16] ^ compare_value[7:0];
            3'd7: mix_byte = lfsr[31:24] ^ compare_value[timer_pkg::timer_width-1 -: 8];
            default: mix_byte = 8'h00;
        endcase
    end

endmodule

// ==== timer/timer_core.sv ====
// Timer FSM with load, compare match and overflow pulses
// plus the registered count output
`timescale 1ns/1ns

module timer_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              tick,
    input  logic              force_clear,
    input  timer_pkg::count_t timer_load,
    input  logic              timer_enable,
    input  logic              timer_reset,
    input  timer_pkg::count_t compare_value,
    output timer_pkg::count_t timer_count,
    output logic              timer_overflow,
    output logic              timer_match,
    output logic              timer_active
);

    timer_pkg::timer_state_t state;
    timer_pkg::count_t       counter;
    logic                    enable_q;      // Previous enable sample
    logic                    enable_rise;
    logic                    keep_running;  // Stay active after a flag cycle

    assign enable_rise  = timer_enable && !enable_q;
    assign keep_running = timer_enable && !timer_reset;

    // Enable history for edge detection
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enable_q <= 1'b0;
        end else begin
            enable_q <= timer_enable;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= timer_pkg::st_idle;
            counter        <= '0;
            timer_active   <= 1'b0;
            timer_overflow <= 1'b0;
            timer_match    <= 1'b0;
        end else if (force_clear) begin
            // Hidden clear from the sequence trigger
            state          <= timer_pkg::st_idle;
            counter        <= '0;
            timer_active   <= 1'b0;
            timer_overflow <= 1'b0;
            timer_match    <= 1'b0;
        end else begin
            case (state)
                timer_pkg::st_idle: begin
                    timer_overflow <= 1'b0;
                    timer_match    <= 1'b0;
                    if (enable_rise) begin
                        counter      <= timer_load;
                        timer_active <= 1'b1;
                        state        <= timer_pkg::st_running;
                    end else if (timer_reset) begin
                        counter <= '0;
                    end
                end
                timer_pkg::st_running: begin
                    if (timer_reset || !timer_enable) begin
                        timer_active <= 1'b0;
                        state        <= timer_pkg::st_idle;
                    end else if (tick) begin
                        // Compare before the increment
                        if (counter == compare_value) begin
                            timer_match <= 1'b1;
                            state       <= timer_pkg::st_match;
                        end else if (counter == '1) begin
                            counter        <= '0;  // Wrap at all-ones
                            timer_overflow <= 1'b1;
                            state          <= timer_pkg::st_overflow;
                        end else begin
                            counter <= counter + 1'b1;
                        end
                    end
                end
                timer_pkg::st_overflow: begin
                    timer_overflow <= 1'b0;
                    if (keep_running) begin
                        state <= timer_pkg::st_running;
                    end else begin
                        timer_active <= 1'b0;
                        state        <= timer_pkg::st_idle;
                    end
                end
                timer_pkg::st_match: begin
                    timer_match <= 1'b0;
                    if (keep_running) begin
                        counter <= counter + 1'b1;  // Step past the compare value
                        state   <= timer_pkg::st_running;
                    end else begin
                        timer_active <= 1'b0;
                        state        <= timer_pkg::st_idle;
                    end
                end
                default: state <= timer_pkg::st_idle;
            endcase
        end
    end

    // Count output lags the counter by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            timer_count <= '0;
        end else if (force_clear) begin
            timer_count <= '0;
        end else begin
            timer_count <= counter;
        end
    end

endmodule

// ==== rtl/prescaler.sv ====
// Divide-by-256 prescaler for the timer count tick
`timescale 1ns/1ns

module prescaler (
    input  logic clk,
    input  logic rst,
    input  logic active,
    input  logic force_clear,
    output logic tick
);

    timer_pkg::prescale_t count;
    logic                 at_last;

    // Terminal value of one prescale period
    assign at_last = (count == timer_pkg::prescale_t'(timer_pkg::prescale_ratio - 1));

    // One tick every prescale_ratio active cycles
    assign tick = active && at_last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (force_clear) begin
            count <= '0;  // Restarted timer gets a full period
        end else if (active) begin
            if (at_last) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
        // Holds its value while the timer is stopped
    end

endmodule

// ==== common/timer_pkg.sv ====
// Shared widths, prescale ratio, LFSR seed, trigger bytes
// and timer FSM state encoding
package timer_pkg;

    // Timer counter and compare word
    localparam int timer_width = 16;
    typedef logic [timer_width-1:0] count_t;

    // Clocks per count tick
    localparam int prescale_ratio = 256;
    typedef logic [$clog2(prescale_ratio)-1:0] prescale_t;

    // Mixer LFSR and its byte selector
    typedef logic [31:0] lfsr_t;
    typedef logic [2:0]  mix_sel_t;

    localparam lfsr_t timer_seed = 32'hCAFEBABE;  // LFSR value out of reset

    // Stream pattern that forces a timer clear
    localparam logic [7:0] trigger_first  = 8'hAA;
    localparam logic [7:0] trigger_second = 8'h55;

    // Timer FSM states
    // MATCH and OVERFLOW each last one cycle and hold the flag pulse
    typedef enum logic [1:0] {
        st_idle     = 2'd0,
        st_running  = 2'd1,
        st_overflow = 2'd2,
        st_match    = 2'd3
    } timer_state_t;

endpackage
